//--- include/agen_regs.svh
`ifndef AGEN_REGS_SVH
`define AGEN_REGS_SVH

// Architectural GPRs, numbered as in ModRM and SIB
localparam int gpr_count = 8;

localparam logic [2:0] reg_eax = 3'd0;
localparam logic [2:0] reg_ecx = 3'd1;
localparam logic [2:0] reg_edx = 3'd2;
localparam logic [2:0] reg_ebx = 3'd3;
localparam logic [2:0] reg_esp = 3'd4;
localparam logic [2:0] reg_ebp = 3'd5;
localparam logic [2:0] reg_esi = 3'd6;
localparam logic [2:0] reg_edi = 3'd7;

// Segment registers, numbered as in the sreg field
localparam logic [2:0] seg_es = 3'd0;
localparam logic [2:0] seg_cs = 3'd1;
localparam logic [2:0] seg_ss = 3'd2;
localparam logic [2:0] seg_ds = 3'd3;
localparam logic [2:0] seg_fs = 3'd4;
localparam logic [2:0] seg_gs = 3'd5;

`endif

//--- rtl/agen_pkg.sv
package agen_pkg;

   localparam int reg_id_w = 3;
   localparam int addr_w   = 32;
   localparam int seg_w    = 16;
   // Far pointer operand is selector:offset
   localparam int off_w    = addr_w + seg_w;

   `include "agen_regs.svh"

   localparam int sb_w   = gpr_count;
   localparam int size_w = 4;

   typedef enum logic [2:0] {
      op_alu,
      op_load,
      op_store,
      op_push,
      op_pop,
      op_jmp_rel,
      op_jmp_abs,
      op_jmp_far
   } uop_op_e;

   typedef enum logic [1:0] {
      a_sr1,
      a_seg1,
      a_seg2,
      a_cs
   } a_sel_e;

   // Encoding 3 is unused
   typedef enum logic [1:0] {
      size_16 = 2'd0,
      size_32 = 2'd1,
      size_64 = 2'd2
   } mem_size_e;

   // Access size in bytes
   function automatic logic [size_w-1:0] size_bytes(input mem_size_e size);
      logic [size_w-1:0] bytes;
      case (size)
         size_16: bytes = 4'd2;
         size_32: bytes = 4'd4;
         size_64: bytes = 4'd8;
         default: bytes = 4'd0;
      endcase
      return bytes;
   endfunction

   // Scoreboard bit of one GPR
   function automatic logic [sb_w-1:0] reg_bit(input logic [reg_id_w-1:0] id);
      logic [sb_w-1:0] bits;
      bits     = '0;
      bits[id] = 1'b1;
      return bits;
   endfunction

endpackage

//--- rtl/agen_decode.sv
module agen_decode (
   input  agen_pkg::uop_op_e op,
   output logic              jmp_rel,
   output logic              next_eip_sel,
   output logic              next_cs_sel,
   output logic              sp_adjust,
   output logic              sp_pop,
   output logic              is_mem,
   output logic              ld_dest
);
   import agen_pkg::*;

   always_comb begin
      jmp_rel      = 1'b0;
      next_eip_sel = 1'b0;
      next_cs_sel  = 1'b0;
      sp_adjust    = 1'b0;
      sp_pop       = 1'b0;
      is_mem       = 1'b0;
      ld_dest      = 1'b0;
      case (op)
         op_alu: begin
            ld_dest = 1'b1;
         end
         op_load: begin
            is_mem  = 1'b1;
            ld_dest = 1'b1;
         end
         op_store: begin
            is_mem = 1'b1;
         end
         op_push: begin
            is_mem    = 1'b1;
            sp_adjust = 1'b1;
         end
         // Pop writes the popped value into dr
         op_pop: begin
            is_mem    = 1'b1;
            sp_adjust = 1'b1;
            sp_pop    = 1'b1;
            ld_dest   = 1'b1;
         end
         op_jmp_rel: begin
            jmp_rel = 1'b1;
         end
         op_jmp_abs: begin
            next_eip_sel = 1'b1;
         end
         // Far jump loads both EIP and CS from the pointer
         op_jmp_far: begin
            next_eip_sel = 1'b1;
            next_cs_sel  = 1'b1;
         end
      endcase
   end

endmodule

//--- rtl/agen_address.sv
module agen_address (
   input  logic [agen_pkg::addr_w-1:0] eip,
   input  logic [agen_pkg::off_w-1:0]  offset,
   input  logic [agen_pkg::addr_w-1:0] imm32,
   input  logic [agen_pkg::addr_w-1:0] disp32,
   input  logic [agen_pkg::addr_w-1:0] sr1_data,
   input  logic [agen_pkg::addr_w-1:0] sr2_data,
   input  logic [agen_pkg::addr_w-1:0] sib_i_data,
   input  logic [agen_pkg::seg_w-1:0]  cs,
   input  logic [agen_pkg::seg_w-1:0]  seg1_data,
   input  logic [agen_pkg::seg_w-1:0]  seg2_data,
   input  logic                        base_en,
   input  logic                        disp_en,
   input  logic                        sib_en,
   input  logic [1:0]                  sib_scale,
   input  logic                        mux_seg,
   input  agen_pkg::a_sel_e            a_sel,
   input  logic                        b_imm,
   input  logic                        jmp_rel,
   input  logic                        next_eip_sel,
   input  logic                        next_cs_sel,
   output logic [agen_pkg::addr_w-1:0] next_eip,
   output logic [agen_pkg::seg_w-1:0]  next_cs,
   output logic [agen_pkg::addr_w-1:0] ea,
   output logic [agen_pkg::addr_w-1:0] a_val,
   output logic [agen_pkg::addr_w-1:0] b_val
);
   import agen_pkg::*;

   localparam int pad_w = addr_w - seg_w;

   logic [addr_w-1:0] rel_off;
   logic [addr_w-1:0] rel_eip;
   logic [seg_w-1:0]  ea_seg;
   logic [addr_w-1:0] ea_seg_base;
   logic [addr_w-1:0] ea_base;
   logic [addr_w-1:0] ea_disp;
   logic [addr_w-1:0] ea_index;

   // Next EIP, relative target or straight from the pointer
   assign rel_off  = jmp_rel ? offset[addr_w-1:0] : '0;
   assign rel_eip  = eip + rel_off;
   assign next_eip = next_eip_sel ? offset[addr_w-1:0] : rel_eip;

   // Far jumps take the selector half of the pointer
   assign next_cs = next_cs_sel ? offset[off_w-1:addr_w] : cs;

   // Real-mode style segment base, selector times 64K
   assign ea_seg      = mux_seg ? cs : seg1_data;
   assign ea_seg_base = {ea_seg, {pad_w{1'b0}}};

   assign ea_base  = base_en ? sr1_data : '0;
   assign ea_disp  = disp_en ? disp32 : '0;
   assign ea_index = sib_en ? (sib_i_data << sib_scale) : '0;

   assign ea = ea_seg_base + ea_base + ea_disp + ea_index;

   // Operand A is a GPR or a zero-extended segment value
   always_comb begin
      case (a_sel)
         a_sr1:   a_val = sr1_data;
         a_seg1:  a_val = {{pad_w{1'b0}}, seg1_data};
         a_seg2:  a_val = {{pad_w{1'b0}}, seg2_data};
         a_cs:    a_val = {{pad_w{1'b0}}, cs};
         default: a_val = sr1_data;
      endcase
   end

   assign b_val = b_imm ? imm32 : sr2_data;

endmodule

//--- rtl/agen_stack.sv
module agen_stack (
   input  logic                        CLK,
   input  logic                        reset,
   input  logic                        accept,
   input  logic [agen_pkg::addr_w-1:0] sr2_data,
   input  agen_pkg::mem_size_e         mem_size,
   input  logic                        sp_adjust,
   input  logic                        sp_pop,
   input  logic                        multi_cont,
   output logic [agen_pkg::addr_w-1:0] sp_addr
);
   import agen_pkg::*;

   localparam int pad_w = addr_w - size_w;

   logic [addr_w-1:0] temp_sp;
   logic [size_w-1:0] prev_pop_size;
   logic [size_w-1:0] cur_size;
   logic [addr_w-1:0] sp_base;
   logic [addr_w-1:0] sp_delta;

   assign cur_size = size_bytes(mem_size);

   // Multi-access sequences keep walking from the saved pointer
   assign sp_base = multi_cont ? temp_sp : sr2_data;

   always_comb begin
      if (!sp_adjust) begin
         sp_delta = '0;
      end else if (sp_pop) begin
         sp_delta = {{pad_w{1'b0}}, prev_pop_size};
      end else begin
         // Push pre-decrements by the access size
         sp_delta = -{{pad_w{1'b0}}, cur_size};
      end
   end

   assign sp_addr = sp_base + sp_delta;

   always_ff @(posedge CLK) begin
      if (reset) begin
         temp_sp       <= '0;
         prev_pop_size <= '0;
      end else if (accept) begin
         temp_sp       <= sp_addr;
         prev_pop_size <= cur_size;
      end
   end

   // Stack ops never carry the spare size code
   assert property (@(posedge CLK) disable iff (reset)
      (accept && sp_adjust) |-> (mem_size inside {size_16, size_32, size_64}))
      else $error("stack access with unused size encoding");

endmodule

//--- rtl/agen_result.sv
module agen_result #(
   parameter int num_fwd_stages = 3
) (
   input  logic                                       CLK,
   input  logic                                       reset,
   input  logic                                       valid,
   input  logic [agen_pkg::reg_id_w-1:0]              sr1,
   input  logic [agen_pkg::reg_id_w-1:0]              sr2,
   input  logic [agen_pkg::reg_id_w-1:0]              dr,
   input  logic                                       sr1_needed,
   input  logic                                       sr2_needed,
   input  logic                                       is_mem,
   input  logic                                       ld_dest,
   input  logic [num_fwd_stages-1:0]                  fwd_v,
   input  logic [num_fwd_stages*agen_pkg::sb_w-1:0]   fwd_sb,
   input  logic [agen_pkg::addr_w-1:0]                next_eip,
   input  logic [agen_pkg::seg_w-1:0]                 next_cs,
   input  logic [agen_pkg::addr_w-1:0]                ea,
   input  logic [agen_pkg::addr_w-1:0]                a_val,
   input  logic [agen_pkg::addr_w-1:0]                b_val,
   input  logic [agen_pkg::addr_w-1:0]                sp_addr,
   output logic                                       stall,
   output logic                                       accept,
   output logic                                       out_v,
   output logic [agen_pkg::addr_w-1:0]                out_next_eip,
   output logic [agen_pkg::seg_w-1:0]                 out_next_cs,
   output logic [agen_pkg::addr_w-1:0]                out_ea,
   output logic [agen_pkg::addr_w-1:0]                out_a,
   output logic [agen_pkg::addr_w-1:0]                out_b,
   output logic [agen_pkg::addr_w-1:0]                out_sp_addr,
   output logic                                       out_mem,
   output logic [agen_pkg::sb_w-1:0]                  out_dr_sb
);
   import agen_pkg::*;

   logic [sb_w-1:0] src_mask;
   logic [sb_w-1:0] dr_sb;
   logic            dep_hit;

   // GPRs this micro-op reads in this stage
   assign src_mask = (sr1_needed ? reg_bit(sr1) : '0) |
                     (sr2_needed ? reg_bit(sr2) : '0);

   // Any valid later stage still writing one of our sources
   always_comb begin
      dep_hit = 1'b0;
      for (int i = 0; i < num_fwd_stages; i++) begin
         if (fwd_v[i] && (|(fwd_sb[i*sb_w +: sb_w] & src_mask))) begin
            dep_hit = 1'b1;
         end
      end
   end

   assign stall  = valid && dep_hit;
   assign accept = valid && !stall;

   assign dr_sb = ld_dest ? reg_bit(dr) : '0;

   always_ff @(posedge CLK) begin
      if (reset) begin
         out_v <= 1'b0;
      end else begin
         out_v <= accept;
      end
   end

   // Payload only moves with an accepted micro-op
   always_ff @(posedge CLK) begin
      if (accept) begin
         out_next_eip <= next_eip;
         out_next_cs  <= next_cs;
         out_ea       <= ea;
         out_a        <= a_val;
         out_b        <= b_val;
         out_sp_addr  <= sp_addr;
         out_mem      <= is_mem;
         out_dr_sb    <= dr_sb;
      end
   end

endmodule

//--- rtl/agen_stage.sv
module agen_stage #(
   parameter int num_fwd_stages = 3
) (
   input  logic                                     CLK,
   input  logic                                     reset,
   input  logic                                     valid,
   input  agen_pkg::uop_op_e                        op,
   input  logic [agen_pkg::reg_id_w-1:0]            sr1,
   input  logic [agen_pkg::reg_id_w-1:0]            sr2,
   input  logic [agen_pkg::reg_id_w-1:0]            dr,
   input  logic                                     sr1_needed,
   input  logic                                     sr2_needed,
   input  logic                                     base_en,
   input  logic                                     disp_en,
   input  logic                                     sib_en,
   input  logic [1:0]                               sib_scale,
   input  logic                                     mux_seg,
   input  agen_pkg::a_sel_e                         a_sel,
   input  logic                                     b_imm,
   input  agen_pkg::mem_size_e                      mem_size,
   input  logic                                     multi_cont,
   input  logic [agen_pkg::addr_w-1:0]              eip,
   input  logic [agen_pkg::seg_w-1:0]               cs,
   input  logic [agen_pkg::off_w-1:0]               offset,
   input  logic [agen_pkg::addr_w-1:0]              imm32,
   input  logic [agen_pkg::addr_w-1:0]              disp32,
   input  logic [agen_pkg::addr_w-1:0]              sr1_data,
   input  logic [agen_pkg::addr_w-1:0]              sr2_data,
   input  logic [agen_pkg::addr_w-1:0]              sib_i_data,
   input  logic [agen_pkg::seg_w-1:0]               seg1_data,
   input  logic [agen_pkg::seg_w-1:0]               seg2_data,
   input  logic [num_fwd_stages-1:0]                fwd_v,
   input  logic [num_fwd_stages*agen_pkg::sb_w-1:0] fwd_sb,
   output logic                                     stall,
   output logic                                     out_v,
   output logic [agen_pkg::addr_w-1:0]              out_next_eip,
   output logic [agen_pkg::seg_w-1:0]               out_next_cs,
   output logic [agen_pkg::addr_w-1:0]              out_ea,
   output logic [agen_pkg::addr_w-1:0]              out_a,
   output logic [agen_pkg::addr_w-1:0]              out_b,
   output logic [agen_pkg::addr_w-1:0]              out_sp_addr,
   output logic                                     out_mem,
   output logic [agen_pkg::sb_w-1:0]                out_dr_sb
);
   import agen_pkg::*;

   logic              jmp_rel;
   logic              next_eip_sel;
   logic              next_cs_sel;
   logic              sp_adjust;
   logic              sp_pop;
   logic              is_mem;
   logic              ld_dest;
   logic              accept;
   logic [addr_w-1:0] next_eip;
   logic [seg_w-1:0]  next_cs;
   logic [addr_w-1:0] ea;
   logic [addr_w-1:0] a_val;
   logic [addr_w-1:0] b_val;
   logic [addr_w-1:0] sp_addr;

   agen_decode u_decode (
      .op           (op),
      .jmp_rel      (jmp_rel),
      .next_eip_sel (next_eip_sel),
      .next_cs_sel  (next_cs_sel),
      .sp_adjust    (sp_adjust),
      .sp_pop       (sp_pop),
      .is_mem       (is_mem),
      .ld_dest      (ld_dest)
   );

   agen_address u_address (
      .eip          (eip),
      .offset       (offset),
      .imm32        (imm32),
      .disp32       (disp32),
      .sr1_data     (sr1_data),
      .sr2_data     (sr2_data),
      .sib_i_data   (sib_i_data),
      .cs           (cs),
      .seg1_data    (seg1_data),
      .seg2_data    (seg2_data),
      .base_en      (base_en),
      .disp_en      (disp_en),
      .sib_en       (sib_en),
      .sib_scale    (sib_scale),
      .mux_seg      (mux_seg),
      .a_sel        (a_sel),
      .b_imm        (b_imm),
      .jmp_rel      (jmp_rel),
      .next_eip_sel (next_eip_sel),
      .next_cs_sel  (next_cs_sel),
      .next_eip     (next_eip),
      .next_cs      (next_cs),
      .ea           (ea),
      .a_val        (a_val),
      .b_val        (b_val)
   );

   // Stack pointer state only moves on accepted micro-ops
   agen_stack u_stack (
      .CLK        (CLK),
      .reset      (reset),
      .accept     (accept),
      .sr2_data   (sr2_data),
      .mem_size   (mem_size),
      .sp_adjust  (sp_adjust),
      .sp_pop     (sp_pop),
      .multi_cont (multi_cont),
      .sp_addr    (sp_addr)
   );

   agen_result #(
      .num_fwd_stages (num_fwd_stages)
   ) u_result (
      .CLK          (CLK),
      .reset        (reset),
      .valid        (valid),
      .sr1          (sr1),
      .sr2          (sr2),
      .dr           (dr),
      .sr1_needed   (sr1_needed),
      .sr2_needed   (sr2_needed),
      .is_mem       (is_mem),
      .ld_dest      (ld_dest),
      .fwd_v        (fwd_v),
      .fwd_sb       (fwd_sb),
      .next_eip     (next_eip),
      .next_cs      (next_cs),
      .ea           (ea),
      .a_val        (a_val),
      .b_val        (b_val),
      .sp_addr      (sp_addr),
      .stall        (stall),
      .accept       (accept),
      .out_v        (out_v),
      .out_next_eip (out_next_eip),
      .out_next_cs  (out_next_cs),
      .out_ea       (out_ea),
      .out_a        (out_a),
      .out_b        (out_b),
      .out_sp_addr  (out_sp_addr),
      .out_mem      (out_mem),
      .out_dr_sb    (out_dr_sb)
   );

endmodule

//--- verification/agen_tb.sv
module agen_tb;
   timeunit 1ns;
   timeprecision 100ps;

   import agen_pkg::*;

   localparam int num_fwd_stages = 3;
   localparam int num_uops       = 600;
   localparam int max_stall      = 40;

   logic                             CLK;
   logic                             reset;
   logic                             valid;
   uop_op_e                          op;
   logic [reg_id_w-1:0]              sr1;
   logic [reg_id_w-1:0]              sr2;
   logic [reg_id_w-1:0]              dr;
   logic                             sr1_needed;
   logic                             sr2_needed;
   logic                             base_en;
   logic                             disp_en;
   logic                             sib_en;
   logic [1:0]                       sib_scale;
   logic                             mux_seg;
   a_sel_e                           a_sel;
   logic                             b_imm;
   mem_size_e                        mem_size;
   logic                             multi_cont;
   logic [addr_w-1:0]                eip;
   logic [seg_w-1:0]                 cs;
   logic [off_w-1:0]                 offset;
   logic [addr_w-1:0]                imm32;
   logic [addr_w-1:0]                disp32;
   logic [addr_w-1:0]                sr1_data;
   logic [addr_w-1:0]                sr2_data;
   logic [addr_w-1:0]                sib_i_data;
   logic [seg_w-1:0]                 seg1_data;
   logic [seg_w-1:0]                 seg2_data;
   logic [num_fwd_stages-1:0]        fwd_v;
   logic [num_fwd_stages*sb_w-1:0]   fwd_sb;
   logic                             stall;
   logic                             out_v;
   logic [addr_w-1:0]                out_next_eip;
   logic [seg_w-1:0]                 out_next_cs;
   logic [addr_w-1:0]                out_ea;
   logic [addr_w-1:0]                out_a;
   logic [addr_w-1:0]                out_b;
   logic [addr_w-1:0]                out_sp_addr;
   logic                             out_mem;
   logic [sb_w-1:0]                  out_dr_sb;

   integer            seed;
   int                uop_idx;
   int                n_accepted;
   int                n_stalls;
   int                n_chained;

   // Reference model state, mirrors the stack registers
   logic [addr_w-1:0] m_temp_sp;
   logic [addr_w-1:0] m_prev_pop;

   // Expected values for the micro-op presented this cycle
   logic              exp_stall;
   logic              exp_out_v;
   logic [addr_w-1:0] exp_next_eip;
   logic [seg_w-1:0]  exp_next_cs;
   logic [addr_w-1:0] exp_ea;
   logic [addr_w-1:0] exp_a;
   logic [addr_w-1:0] exp_b;
   logic [addr_w-1:0] exp_sp;
   logic              exp_mem;
   logic [sb_w-1:0]   exp_dr_sb;

   agen_stage #(
      .num_fwd_stages (num_fwd_stages)
   ) dut (.*);

   initial begin
      CLK = 1'b0;
      forever #50 CLK = ~CLK;
   end

   task automatic abort_run(input string what);
      $display("%s", what);
      $display("Errors found");
      $fatal(1, "stopping at the first error");
   endtask

   task automatic check(input string name, input logic [63:0] expected,
                        input logic [63:0] actual);
      if (expected !== actual) begin
         abort_run($sformatf("Fail %s at uop %0d expected %0h actual %0h",
                             name, uop_idx, expected, actual));
      end
   endtask

   function automatic logic [addr_w-1:0] access_bytes(input mem_size_e size);
      case (size)
         size_16: access_bytes = 32'd2;
         size_32: access_bytes = 32'd4;
         default: access_bytes = 32'd8;
      endcase
   endfunction

   // New upstream micro-op, held by the caller while stalled
   task automatic drive_uop();
      logic [31:0] r;
      logic [31:0] r2;
      r          = $random(seed);
      r2         = $random(seed);
      valid      = (r[2:0] != 3'd0);
      op         = uop_op_e'(r[5:3]);
      sr1        = r[8:6];
      sr2        = r[11:9];
      dr         = r[14:12];
      sr1_needed = r[15];
      sr2_needed = r[16];
      base_en    = r[17];
      disp_en    = r[18];
      sib_en     = r[19];
      sib_scale  = r[21:20];
      mux_seg    = r[22];
      a_sel      = a_sel_e'(r[24:23]);
      b_imm      = r[25];
      // Never the spare size code
      mem_size   = (r[27:26] == 2'd3) ? size_32 : mem_size_e'(r[27:26]);
      multi_cont = r[28];
      cs         = r2[31:16];
      offset[off_w-1:addr_w] = r2[15:0];
      offset[addr_w-1:0]     = $random(seed);
      r          = $random(seed);
      seg1_data  = r[31:16];
      seg2_data  = r[15:0];
      eip        = $random(seed);
      imm32      = $random(seed);
      disp32     = $random(seed);
      sr1_data   = $random(seed);
      sr2_data   = $random(seed);
      sib_i_data = $random(seed);
   endtask

   // Later stages change every cycle, two sparse bits each
   task automatic drive_scoreboards();
      logic [31:0] r;
      for (int i = 0; i < num_fwd_stages; i++) begin
         r = $random(seed);
         fwd_v[i] = r[0];
         fwd_sb[i*sb_w +: sb_w] = (8'b1 << r[3:1]) | (8'b1 << r[6:4]);
      end
   endtask

   task automatic predict();
      logic [sb_w-1:0]   mask;
      logic              hit;
      logic              ld;
      logic [addr_w-1:0] sp_base;
      mask = '0;
      if (sr1_needed) mask = mask | (8'b1 << sr1);
      if (sr2_needed) mask = mask | (8'b1 << sr2);
      hit = 1'b0;
      for (int i = 0; i < num_fwd_stages; i++) begin
         if (fwd_v[i] && ((fwd_sb[i*sb_w +: sb_w] & mask) != '0)) hit = 1'b1;
      end
      exp_stall = valid && hit;
      exp_out_v = valid && !hit;

      case (op)
         op_jmp_rel:             exp_next_eip = eip + offset[addr_w-1:0];
         op_jmp_abs, op_jmp_far: exp_next_eip = offset[addr_w-1:0];
         default:                exp_next_eip = eip;
      endcase
      exp_next_cs = (op == op_jmp_far) ? offset[off_w-1:addr_w] : cs;

      // Segment times 64K plus the enabled terms
      exp_ea = {(mux_seg ? cs : seg1_data), 16'h0000};
      if (base_en) exp_ea = exp_ea + sr1_data;
      if (disp_en) exp_ea = exp_ea + disp32;
      if (sib_en) exp_ea = exp_ea + (sib_i_data << sib_scale);

      case (a_sel)
         a_seg1:  exp_a = {16'h0000, seg1_data};
         a_seg2:  exp_a = {16'h0000, seg2_data};
         a_cs:    exp_a = {16'h0000, cs};
         default: exp_a = sr1_data;
      endcase
      exp_b = b_imm ? imm32 : sr2_data;

      exp_mem   = op inside {op_load, op_store, op_push, op_pop};
      ld        = op inside {op_alu, op_load, op_pop};
      exp_dr_sb = ld ? (8'b1 << dr) : 8'b0;

      sp_base = multi_cont ? m_temp_sp : sr2_data;
      case (op)
         op_push: exp_sp = sp_base - access_bytes(mem_size);
         op_pop:  exp_sp = sp_base + m_prev_pop;
         default: exp_sp = sp_base;
      endcase

      // Stack state moves only with an accepted micro-op
      if (exp_out_v) begin
         m_temp_sp  = exp_sp;
         m_prev_pop = access_bytes(mem_size);
         n_accepted++;
         if (multi_cont && (op inside {op_push, op_pop})) n_chained++;
      end
      if (exp_stall) n_stalls++;
   endtask

   task automatic check_outputs();
      check("out_v", 64'(exp_out_v), 64'(out_v));
      if (exp_out_v) begin
         check("out_next_eip", 64'(exp_next_eip), 64'(out_next_eip));
         check("out_next_cs", 64'(exp_next_cs), 64'(out_next_cs));
         check("out_ea", 64'(exp_ea), 64'(out_ea));
         check("out_a", 64'(exp_a), 64'(out_a));
         check("out_b", 64'(exp_b), 64'(out_b));
         check("out_sp_addr", 64'(exp_sp), 64'(out_sp_addr));
         check("out_mem", 64'(exp_mem), 64'(out_mem));
         check("out_dr_sb", 64'(exp_dr_sb), 64'(out_dr_sb));
      end
   endtask

   initial begin
      int stalled;
      seed       = 32'hd1716542;
      uop_idx    = 0;
      n_accepted = 0;
      n_stalls   = 0;
      n_chained  = 0;
      m_temp_sp  = '0;
      m_prev_pop = '0;
      reset      = 1'b1;
      valid      = 1'b0;
      op         = op_alu;
      sr1        = '0;
      sr2        = '0;
      dr         = '0;
      sr1_needed = 1'b0;
      sr2_needed = 1'b0;
      base_en    = 1'b0;
      disp_en    = 1'b0;
      sib_en     = 1'b0;
      sib_scale  = '0;
      mux_seg    = 1'b0;
      a_sel      = a_sr1;
      b_imm      = 1'b0;
      mem_size   = size_16;
      multi_cont = 1'b0;
      eip        = '0;
      cs         = '0;
      offset     = '0;
      imm32      = '0;
      disp32     = '0;
      sr1_data   = '0;
      sr2_data   = '0;
      sib_i_data = '0;
      seg1_data  = '0;
      seg2_data  = '0;
      fwd_v      = '0;
      fwd_sb     = '0;

      repeat (3) @(posedge CLK);
      #1 reset = 1'b0;
      check("reset out_v", 64'(1'b0), 64'(out_v));
      check("reset stall", 64'(1'b0), 64'(stall));

      for (uop_idx = 0; uop_idx < num_uops; uop_idx++) begin
         drive_uop();
         stalled = 0;
         // Hold the micro-op until the dependency clears
         do begin
            drive_scoreboards();
            #1;
            predict();
            check("stall", 64'(exp_stall), 64'(stall));
            @(posedge CLK);
            #1;
            check_outputs();
            if (exp_stall) begin
               stalled++;
               if (stalled > max_stall) begin
                  abort_run("stall did not clear within the timeout");
               end
            end
         end while (exp_stall);
      end

      if (n_stalls == 0 || n_chained == 0) begin
         abort_run("random stimulus never reached a stall or a chained stack access");
      end else begin
         $display("accepted %0d micro-ops, %0d stall cycles, %0d chained stack ops",
                  n_accepted, n_stalls, n_chained);
         $display("No errors");
         $finish;
      end
   end

endmodule

//--- build.f
+incdir+include
rtl/agen_pkg.sv
rtl/agen_decode.sv
rtl/agen_address.sv
rtl/agen_stack.sv
rtl/agen_result.sv
rtl/agen_stage.sv
verification/agen_tb.sv

//--- Makefile
TOP := agen_tb

.PHONY: all run lint clean

all: run

run:
	verilator --binary --timing --assert --timescale 1ns/100ps -j 0 \
		-f build.f --top-module $(TOP) -Mdir obj_dir -o $(TOP)
	./obj_dir/$(TOP)

lint:
	verilator --lint-only --timing --timescale 1ns/100ps \
		-f build.f --top-module $(TOP)

clean:
	rm -rf obj_dir
